/* Bender.yml */
package:
  name: nand_cpu

sources:
  - common/nand_cpu_pkg.sv
  - decoder/decoder.sv
  - verilog/regfile.sv
  - verilog/alu.sv
  - verilog/control_unit.sv
  - verilog/nand_cpu.sv
  - target: simulation
    files:
      - bench/cpu_checker.sv
      - bench/nand_cpu_tb.sv

/* bench/cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [nand_cpu_pkg::pc_width-1:0]   imem_addr,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [nand_cpu_pkg::data_width-1:0] wb_adr,
    input  logic [nand_cpu_pkg::data_width-1:0] wb_dat_o,
    input  logic                                wb_ack,
    input  logic                                halted,
    input  logic                                trap,
    input  logic [nand_cpu_pkg::imm_width-1:0]  trap_code
);
    import nand_cpu_pkg::*;

    localparam int mem_words  = 256;
    localparam int step_limit = 4096;

    logic [instr_width-1:0] prog [mem_words];
    logic [data_width-1:0]  data_mem [mem_words];

    logic [data_width-1:0]  exp_adr [$];
    logic                   exp_we [$];
    logic [data_width-1:0]  exp_dat [$];
    logic [imm_width-1:0]   exp_trap [$];

    int                     errors = 0;
    int                     bus_checked = 0;
    int                     trap_checked = 0;
    bit                     after_reset = 1'b0;
    bit                     halt_seen = 1'b0;
    bit                     in_cycle = 1'b0;
    logic [data_width-1:0]  held_adr;
    logic                   held_we;
    logic [data_width-1:0]  held_dat;

    task automatic load_instr(input int addr, input logic [instr_width-1:0] value);
        prog[addr] = value;
    endtask

    task automatic load_data(input int addr, input logic [data_width-1:0] value);
        data_mem[addr] = value;
    endtask

    task automatic report_mismatch(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
    endtask

    // Instruction-level model filling the expected bus and trap sequences
    task automatic run_model();
        logic [data_width-1:0]  r [16];
        logic [data_width-1:0]  tv;
        logic [data_width-1:0]  imm_word;
        logic [pc_width-1:0]    pc;
        logic [pc_width-1:0]    pc_next;
        logic [instr_width-1:0] ins;
        logic [3:0]             t;
        logic                   flag;
        bit                     done;
        int                     steps;
        int                     sh;
        errors       = 0;
        bus_checked  = 0;
        trap_checked = 0;
        exp_adr.delete();
        exp_we.delete();
        exp_dat.delete();
        exp_trap.delete();
        for (int i = 0; i < 16; i++) begin
            r[i] = '0;
        end
        flag  = 1'b0;
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < step_limit) begin
            ins      = (pc < mem_words) ? prog[pc[7:0]] : 8'hff;
            t        = ins[3:0];
            tv       = r[t];
            imm_word = t;
            pc_next  = pc + 1;
            case (ins[7:4])
                4'h0: begin
                    if (t == 0) begin
                        r[0] = '0;
                    end else begin
                        r[t] = r[0];
                    end
                end
                4'h1: r[0] = ~(r[0] & tv);
                4'h2: r[0] = r[0] << tv[3:0];
                4'h3: r[0] = r[0] >> tv[3:0];
                4'h4: flag = (r[0] == tv);
                4'h5: flag = (r[0] != tv);
                4'h6: begin
                    if (flag) begin
                        pc_next = tv;
                    end
                end
                4'h7: begin
                    r[t]    = pc + 1;   // Link, then jump to the old rt
                    pc_next = tv;
                end
                4'h8, 4'h9, 4'ha, 4'hb: begin
                    sh   = 4 * ins[5:4];
                    r[0] = (r[0] & ~(16'hf << sh)) | (imm_word << sh);
                end
                4'hc: begin
                    exp_adr.push_back(tv);
                    exp_we.push_back(1'b0);
                    exp_dat.push_back(r[0]);
                    r[0] = data_mem[tv[7:0]];
                end
                4'hd: begin
                    exp_adr.push_back(tv);
                    exp_we.push_back(1'b1);
                    exp_dat.push_back(r[0]);
                    data_mem[tv[7:0]] = r[0];
                end
                4'he: exp_trap.push_back(t);
                default: done = 1'b1;
            endcase
            pc = pc_next;
            steps++;
        end
        if (!done) begin
            $display("Reference model did not reach HLT within %0d instructions", step_limit);
            errors++;
        end
    endtask

    task automatic compare_bus_cycle();
        logic [data_width-1:0] a;
        logic                  w;
        logic [data_width-1:0] d;
        if (exp_adr.size() == 0) begin
            report_mismatch($sformatf("unexpected bus cycle adr %04h we %b", wb_adr, wb_we));
        end else begin
            a = exp_adr.pop_front();
            w = exp_we.pop_front();
            d = exp_dat.pop_front();
            if (wb_adr !== a || wb_we !== w || (w && wb_dat_o !== d)) begin
                report_mismatch($sformatf("bus adr %04h we %b dat %04h, expected %04h %b %04h",
                                          wb_adr, wb_we, wb_dat_o, a, w, d));
            end
            bus_checked++;
        end
    endtask

    task automatic compare_trap();
        logic [imm_width-1:0] code;
        if (exp_trap.size() == 0) begin
            report_mismatch($sformatf("unexpected trap with code %0h", trap_code));
        end else begin
            code = exp_trap.pop_front();
            if (trap_code !== code) begin
                report_mismatch($sformatf("trap code %0h, expected %0h", trap_code, code));
            end
            trap_checked++;
        end
    endtask

    task automatic end_of_test(output int test_errors, output int bus_count,
                               output int trap_count);
        if (halted !== 1'b1) begin
            report_mismatch("core not halted at end of test");
        end
        if (exp_adr.size() != 0) begin
            report_mismatch($sformatf("%0d expected bus cycles missing", exp_adr.size()));
        end
        if (exp_trap.size() != 0) begin
            report_mismatch($sformatf("%0d expected traps missing", exp_trap.size()));
        end
        test_errors = errors;
        bus_count   = bus_checked;
        trap_count  = trap_checked;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            after_reset = 1'b1;
            halt_seen   = 1'b0;
            in_cycle    = 1'b0;
        end else begin
            if (after_reset) begin  // First cycle out of reset
                if (imem_addr !== '0 || wb_cyc !== 1'b0 || trap !== 1'b0 || halted !== 1'b0) begin
                    report_mismatch($sformatf("after reset imem_addr %04h cyc %b trap %b halted %b",
                                              imem_addr, wb_cyc, trap, halted));
                end
                after_reset = 1'b0;
            end
            if (wb_stb !== wb_cyc) begin
                report_mismatch($sformatf("wb_stb %b differs from wb_cyc %b", wb_stb, wb_cyc));
            end
            if (wb_cyc) begin
                if (halt_seen) begin
                    report_mismatch("bus cycle after halt");
                end
                if (!in_cycle) begin
                    held_adr = wb_adr;
                    held_we  = wb_we;
                    held_dat = wb_dat_o;
                    in_cycle = 1'b1;
                end else if (wb_adr !== held_adr || wb_we !== held_we
                             || wb_dat_o !== held_dat) begin
                    report_mismatch("bus payload changed before ack");
                end
                if (wb_ack) begin
                    compare_bus_cycle();
                    in_cycle = 1'b0;
                end
            end
            if (trap) begin
                compare_trap();
            end
            if (halted) begin
                halt_seen = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/nand_cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_cpu_tb;
    import nand_cpu_pkg::*;

    localparam int mem_words    = 256;
    localparam int halt_timeout = 20000;  // Cycles per test

    logic                   clk;
    logic                   rst;
    logic [pc_width-1:0]    imem_addr;
    logic [instr_width-1:0] imem_data;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [data_width-1:0]  wb_adr;
    logic [data_width-1:0]  wb_dat_o;
    logic [data_width-1:0]  wb_dat_i;
    logic                   wb_ack;
    logic                   halted;
    logic                   trap;
    logic [imm_width-1:0]   trap_code;

    logic [instr_width-1:0] imem [mem_words];
    logic [data_width-1:0]  dmem [mem_words];
    int                     wp;
    int                     ack_delay;
    int                     seed;
    int                     seed_draw;
    int                     passed_tests;
    int                     failed_tests;
    bit                     timed_out;

    nand_cpu i_nand_cpu (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_o  (wb_dat_o),
        .wb_dat_i  (wb_dat_i),
        .wb_ack    (wb_ack),
        .halted    (halted),
        .trap      (trap),
        .trap_code (trap_code)
    );

    cpu_checker i_cpu_checker (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack),
        .halted    (halted),
        .trap      (trap),
        .trap_code (trap_code)
    );

    // Out of range fetches read HLT
    assign imem_data = (imem_addr < mem_words) ? imem[imem_addr[7:0]] : 8'hff;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Wishbone slave with 0 to 5 wait states
    always @(negedge clk) begin
        if (rst || !(wb_cyc && wb_stb) || wb_ack) begin
            wb_ack    = 1'b0;
            ack_delay = $urandom_range(5, 0);
        end else if (ack_delay == 0) begin
            wb_ack   = 1'b1;
            wb_dat_i = dmem[wb_adr[7:0]];
            if (wb_we) begin
                dmem[wb_adr[7:0]] = wb_dat_o;
            end
        end else begin
            ack_delay--;
        end
    end

    task automatic emit(input logic [instr_width-1:0] b);
        imem[wp] = b;
        wp++;
    endtask

    // Random instruction whose opcode nibble is set in allowed
    function automatic logic [instr_width-1:0] pick_instr(input logic [15:0] allowed);
        int nib;
        nib = $urandom_range(15, 0);
        while (!allowed[nib]) begin
            nib = $urandom_range(15, 0);
        end
        return nib * 16 + $urandom_range(15, 0);
    endfunction

    // Loads a forward target into rt with LI, then BR or JRL over a few filler bytes
    task automatic emit_jump_block();
        int rt;
        int skip;
        int target;
        bit use_jrl;
        rt      = $urandom_range(15, 1);
        skip    = $urandom_range(3, 0);
        use_jrl = $urandom_range(1, 0);
        target  = wp + (use_jrl ? 5 : 7) + skip;
        emit(8'h00);
        emit(8'h80 + target % 16);
        emit(8'h90 + target / 16);
        emit(rt);
        if (use_jrl) begin
            emit(8'h70 + rt);
        end else begin
            emit(8'h80 + $urandom_range(63, 0));  // Disturb r0 before compare
            emit(8'h40 + $urandom_range(31, 0));
            emit(8'h60 + rt);
        end
        repeat (skip) begin
            emit(pick_instr(16'h3f3f));
        end
    endtask

    task automatic build_program(input int kind);
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = 8'hff;
            dmem[i] = $urandom_range(16'hffff, 0);
        end
        wp = 0;
        case (kind)
            1: while (wp < 120) emit(pick_instr(16'h2f0f));  // LI CL CP NND LS RS ST
            2: while (wp < 120) emit(pick_instr(16'h3f03));  // LD ST heavy
            3: begin
                while (wp < 180) begin
                    if ($urandom_range(3, 0) == 0) begin
                        emit_jump_block();
                    end else begin
                        emit(pick_instr(16'h3f3f));
                    end
                end
            end
            4: while (wp < 120) emit(pick_instr(16'h6f03));  // With INT
            default: ;
        endcase
        emit(8'hf0 + $urandom_range(15, 0));
        for (int i = 0; i < mem_words; i++) begin
            i_cpu_checker.load_instr(i, imem[i]);
            i_cpu_checker.load_data(i, dmem[i]);
        end
    endtask

    task automatic run_test(input string name, input int kind);
        int cycles;
        int errs;
        int buses;
        int traps;
        build_program(kind);
        i_cpu_checker.run_model();
        @(negedge clk);
        rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        cycles = 0;
        while (!halted && cycles < halt_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: core did not halt within %0d cycles in test %s",
                     halt_timeout, name);
            timed_out = 1'b1;
            failed_tests++;
        end else begin
            repeat (4) @(negedge clk);  // Catches a late bus cycle
            i_cpu_checker.end_of_test(errs, buses, traps);
            $display("test %s %s: %0d bus cycles, %0d traps, %0d mismatches",
                     name, (errs == 0) ? "passed" : "failed", buses, traps, errs);
            if (errs == 0) begin
                passed_tests++;
            end else begin
                failed_tests++;
            end
        end
    endtask

    initial begin
        rst          = 1'b1;
        wb_ack       = 1'b0;
        wb_dat_i     = '0;
        passed_tests = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        wp           = 0;
        ack_delay    = 0;
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = 8'hff;
            dmem[i] = '0;
        end
        seed      = 32'hf56b3faf;
        seed_draw = $urandom(seed);
        run_test("reset", 0);
        if (!timed_out) run_test("arith", 1);
        if (!timed_out) run_test("memory", 2);
        if (!timed_out) run_test("control", 3);
        if (!timed_out) run_test("int_hlt", 4);
        $display("Tests: %0d passed, %0d failed", passed_tests, failed_tests);
        if (failed_tests == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* common/nand_cpu_pkg.sv */
`default_nettype none

package nand_cpu_pkg;

    localparam int data_width     = 16;
    localparam int reg_addr_width = 4;
    localparam int instr_width    = 8;
    localparam int pc_width       = 16;
    localparam int imm_width      = 4;
    localparam int shamt_width    = $clog2(data_width);  // Shift amount taken from rt

    typedef enum logic [3:0] {
        alu_clr,
        alu_cp,
        alu_nand,
        alu_ls,
        alu_rs,
        alu_eq,
        alu_ne,
        alu_li,
        alu_none                        // BR, JRL, LD, ST, INT, HLT
    } alu_op_e;

    typedef enum logic {
        mem_read,
        mem_write
    } mem_op_e;

    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_mem,                         // Waiting for wb_ack
        st_halt
    } core_state_e;

endpackage

`default_nettype wire

/* decoder/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  logic [nand_cpu_pkg::instr_width-1:0]    instr,
    output logic                                    use_ra,
    output logic                                    use_rt,
    output logic                                    use_rw,
    output logic [nand_cpu_pkg::reg_addr_width-1:0] rt_addr,
    output logic [nand_cpu_pkg::reg_addr_width-1:0] rw_addr,
    output logic                                    read_ps,
    output logic                                    write_ps,
    output logic                                    use_immdt,
    output logic [nand_cpu_pkg::imm_width-1:0]      immdt,
    output logic [1:0]                              shift,
    output logic                                    mem_access,
    output nand_cpu_pkg::mem_op_e                   mem_op,
    output logic                                    jump,
    output logic                                    branch,
    output logic                                    interrupt,
    output logic                                    halt,
    output nand_cpu_pkg::alu_op_e                   alu_op
);
    import nand_cpu_pkg::*;

    always_comb begin
        use_ra     = 1'b0;
        use_rt     = 1'b0;
        use_rw     = 1'b0;
        rt_addr    = instr[3:0];
        rw_addr    = '0;                // Accumulator unless overridden
        read_ps    = 1'b0;
        write_ps   = 1'b0;
        use_immdt  = 1'b0;
        immdt      = instr[3:0];
        shift      = instr[5:4];
        mem_access = 1'b0;
        mem_op     = mem_read;
        jump       = 1'b0;
        branch     = 1'b0;
        interrupt  = 1'b0;
        halt       = 1'b0;
        alu_op     = alu_none;
        priority casez (instr)
            8'b00000000: begin          // CL
                use_rw = 1'b1;
                alu_op = alu_clr;
            end
            8'b0000????: begin          // CP
                use_ra  = 1'b1;
                use_rw  = 1'b1;
                rw_addr = instr[3:0];
                alu_op  = alu_cp;
            end
            8'b0001????: begin          // NND
                use_ra = 1'b1;
                use_rt = 1'b1;
                use_rw = 1'b1;
                alu_op = alu_nand;
            end
            8'b0010????, 8'b0011????: begin  // LS, RS
                use_ra = 1'b1;
                use_rt = 1'b1;
                use_rw = 1'b1;
                alu_op = instr[4] ? alu_rs : alu_ls;
            end
            8'b010?????: begin          // EQ, NE
                use_ra   = 1'b1;
                use_rt   = 1'b1;
                write_ps = 1'b1;
                alu_op   = instr[4] ? alu_ne : alu_eq;
            end
            8'b0110????: begin          // BR
                use_rt  = 1'b1;
                read_ps = 1'b1;
                branch  = 1'b1;
            end
            8'b0111????: begin          // JRL
                use_rt  = 1'b1;
                use_rw  = 1'b1;
                rw_addr = instr[3:0];
                jump    = 1'b1;
            end
            8'b10??????: begin          // LI
                use_ra    = 1'b1;
                use_rw    = 1'b1;
                use_immdt = 1'b1;
                alu_op    = alu_li;
            end
            8'b110?????: begin          // LD, ST
                use_rt     = 1'b1;
                use_ra     = instr[4];
                use_rw     = !instr[4];
                mem_access = 1'b1;
                mem_op     = instr[4] ? mem_write : mem_read;
            end
            8'b1110????: begin          // INT
                use_immdt = 1'b1;
                interrupt = 1'b1;
            end
            8'b1111????: begin          // HLT
                use_immdt = 1'b1;
                halt      = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* sources.f */
common/nand_cpu_pkg.sv
decoder/decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/control_unit.sv
verilog/nand_cpu.sv
bench/cpu_checker.sv
bench/nand_cpu_tb.sv

/* verilog/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  nand_cpu_pkg::alu_op_e               alu_op,
    input  logic [nand_cpu_pkg::data_width-1:0] ra_data,
    input  logic [nand_cpu_pkg::data_width-1:0] rt_data,
    input  logic [nand_cpu_pkg::imm_width-1:0]  immdt,
    input  logic [1:0]                          shift,
    output logic [nand_cpu_pkg::data_width-1:0] result,
    output logic                                ps_next
);
    import nand_cpu_pkg::*;

    logic [shamt_width-1:0] shamt;

    assign shamt = rt_data[shamt_width-1:0];

    always_comb begin
        result  = ra_data;
        ps_next = 1'b0;
        case (alu_op)
            alu_clr: begin
                result = '0;
            end
            alu_cp: begin
                result = ra_data;
            end
            alu_nand: begin
                result = ~(ra_data & rt_data);
            end
            alu_ls: begin
                result = ra_data << shamt;  // Logical
            end
            alu_rs: begin
                result = ra_data >> shamt;
            end
            alu_eq: begin
                ps_next = (ra_data == rt_data);
            end
            alu_ne: begin
                ps_next = (ra_data != rt_data);
            end
            alu_li: begin
                result[{shift, 2'b00} +: imm_width] = immdt;  // Nibble 0..3
            end
            default: begin
                result = ra_data;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic                                 clk,
    input  logic                                 rst,
    output logic [nand_cpu_pkg::pc_width-1:0]    imem_addr,
    input  logic [nand_cpu_pkg::instr_width-1:0] imem_data,
    output logic [nand_cpu_pkg::instr_width-1:0] instr,
    input  logic                                 use_rw,
    input  logic                                 read_ps,
    input  logic                                 write_ps,
    input  logic                                 mem_access,
    input  nand_cpu_pkg::mem_op_e                mem_op,
    input  logic                                 jump,
    input  logic                                 branch,
    input  logic                                 interrupt,
    input  logic                                 halt,
    input  logic [nand_cpu_pkg::imm_width-1:0]   immdt,
    input  logic [nand_cpu_pkg::data_width-1:0]  rt_data,
    input  logic [nand_cpu_pkg::data_width-1:0]  ra_data,
    input  logic [nand_cpu_pkg::data_width-1:0]  alu_result,
    input  logic                                 ps,
    output logic                                 reg_we,
    output logic                                 ps_we,
    output logic [nand_cpu_pkg::data_width-1:0]  wdata,
    output logic                                 wb_cyc,
    output logic                                 wb_stb,
    output logic                                 wb_we,
    output logic [nand_cpu_pkg::data_width-1:0]  wb_adr,
    output logic [nand_cpu_pkg::data_width-1:0]  wb_dat_o,
    input  logic [nand_cpu_pkg::data_width-1:0]  wb_dat_i,
    input  logic                                 wb_ack,
    output logic                                 halted,
    output logic                                 trap,
    output logic [nand_cpu_pkg::imm_width-1:0]   trap_code
);
    import nand_cpu_pkg::*;

    core_state_e         state;
    logic [pc_width-1:0] pc;
    logic [pc_width-1:0] pc_inc;
    logic                redirect;
    logic                ld_done;

    assign imem_addr = pc;
    assign pc_inc    = pc + 1'b1;
    assign redirect  = jump || (branch && read_ps && ps);  // Target is rt
    assign ld_done   = (state == st_mem) && wb_ack && (mem_op == mem_read);

    // Memory writes back only on the ack cycle
    assign reg_we = ((state == st_exec) && use_rw && !mem_access) || (ld_done && use_rw);
    assign ps_we  = (state == st_exec) && write_ps;

    always_comb begin
        if (mem_access) begin
            wdata = wb_dat_i;
        end else if (jump) begin
            wdata = pc_inc;             // JRL link
        end else begin
            wdata = alu_result;
        end
    end

    assign halted    = (state == st_halt);
    assign trap      = (state == st_exec) && interrupt;
    assign trap_code = immdt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_fetch;
            pc     <= '0;
            instr  <= '0;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    instr <= imem_data;
                    state <= st_exec;
                end
                st_exec: begin
                    if (halt) begin
                        state <= st_halt;
                    end else if (mem_access) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        state  <= st_mem;
                    end else begin
                        pc    <= redirect ? rt_data : pc_inc;
                        state <= st_fetch;
                    end
                end
                st_mem: begin
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        pc     <= pc_inc;
                        state  <= st_fetch;
                    end
                end
                st_halt: begin
                    state <= st_halt;   // Only reset leaves
                end
                default: begin
                    state <= st_fetch;
                end
            endcase
        end
    end

    // Bus payload is captured once and held for the whole cycle
    always_ff @(posedge clk) begin
        if ((state == st_exec) && mem_access && !halt) begin
            wb_adr   <= rt_data;
            wb_we    <= (mem_op == mem_write);
            wb_dat_o <= ra_data;
        end
    end

    a_no_bus_halted: assert property (@(posedge clk) disable iff (rst) halted |=> !wb_cyc);

    a_hold_until_ack: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o));

endmodule

`default_nettype wire

/* verilog/nand_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_cpu (
    input  logic                                 clk,
    input  logic                                 rst,
    output logic [nand_cpu_pkg::pc_width-1:0]    imem_addr,
    input  logic [nand_cpu_pkg::instr_width-1:0] imem_data,
    output logic                                 wb_cyc,
    output logic                                 wb_stb,
    output logic                                 wb_we,
    output logic [nand_cpu_pkg::data_width-1:0]  wb_adr,
    output logic [nand_cpu_pkg::data_width-1:0]  wb_dat_o,
    input  logic [nand_cpu_pkg::data_width-1:0]  wb_dat_i,
    input  logic                                 wb_ack,
    output logic                                 halted,
    output logic                                 trap,
    output logic [nand_cpu_pkg::imm_width-1:0]   trap_code
);
    import nand_cpu_pkg::*;

    logic [instr_width-1:0]    instr;
    logic                      use_rw;
    logic [reg_addr_width-1:0] rt_addr;
    logic [reg_addr_width-1:0] rw_addr;
    logic                      read_ps;
    logic                      write_ps;
    logic [imm_width-1:0]      immdt;
    logic [1:0]                shift;
    logic                      mem_access;
    mem_op_e                   mem_op;
    logic                      jump;
    logic                      branch;
    logic                      interrupt;
    logic                      halt;
    alu_op_e                   alu_op;
    logic [data_width-1:0]     ra_data;
    logic [data_width-1:0]     rt_data;
    logic                      ps;
    logic [data_width-1:0]     alu_result;
    logic                      ps_next;
    logic                      reg_we;
    logic                      ps_we;
    logic [data_width-1:0]     wdata;

    decoder i_decoder (
        .instr      (instr),
        .use_ra     (),
        .use_rt     (),
        .use_rw     (use_rw),
        .rt_addr    (rt_addr),
        .rw_addr    (rw_addr),
        .read_ps    (read_ps),
        .write_ps   (write_ps),
        .use_immdt  (),
        .immdt      (immdt),
        .shift      (shift),
        .mem_access (mem_access),
        .mem_op     (mem_op),
        .jump       (jump),
        .branch     (branch),
        .interrupt  (interrupt),
        .halt       (halt),
        .alu_op     (alu_op)
    );

    regfile i_regfile (
        .clk     (clk),
        .rst     (rst),
        .rt_addr (rt_addr),
        .rw_addr (rw_addr),
        .we      (reg_we),
        .ps_we   (ps_we),
        .wdata   (wdata),
        .ps_in   (ps_next),
        .ra_data (ra_data),
        .rt_data (rt_data),
        .ps      (ps)
    );

    alu i_alu (
        .alu_op  (alu_op),
        .ra_data (ra_data),
        .rt_data (rt_data),
        .immdt   (immdt),
        .shift   (shift),
        .result  (alu_result),
        .ps_next (ps_next)
    );

    control_unit i_control_unit (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .instr      (instr),
        .use_rw     (use_rw),
        .read_ps    (read_ps),
        .write_ps   (write_ps),
        .mem_access (mem_access),
        .mem_op     (mem_op),
        .jump       (jump),
        .branch     (branch),
        .interrupt  (interrupt),
        .halt       (halt),
        .immdt      (immdt),
        .rt_data    (rt_data),
        .ra_data    (ra_data),
        .alu_result (alu_result),
        .ps         (ps),
        .reg_we     (reg_we),
        .ps_we      (ps_we),
        .wdata      (wdata),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_o   (wb_dat_o),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack),
        .halted     (halted),
        .trap       (trap),
        .trap_code  (trap_code)
    );

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [nand_cpu_pkg::reg_addr_width-1:0] rt_addr,
    input  logic [nand_cpu_pkg::reg_addr_width-1:0] rw_addr,
    input  logic                                    we,
    input  logic                                    ps_we,
    input  logic [nand_cpu_pkg::data_width-1:0]     wdata,
    input  logic                                    ps_in,
    output logic [nand_cpu_pkg::data_width-1:0]     ra_data,
    output logic [nand_cpu_pkg::data_width-1:0]     rt_data,
    output logic                                    ps
);
    import nand_cpu_pkg::*;

    logic [data_width-1:0] regs [2**reg_addr_width];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
            ps <= 1'b0;
        end else begin
            if (we) begin
                regs[rw_addr] <= wdata;
            end
            if (ps_we) begin
                ps <= ps_in;
            end
        end
    end

    assign ra_data = regs[0];           // r0 is the accumulator
    assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire
